// ==== verilog.f ====
+incdir+include
verilog/cgra_pkg.sv
verilog/tile_cfg_if.sv
verilog/config_decode.sv
verilog/switch_box.sv
verilog/connect_box.sv
verilog/logic_block.sv
verilog/pe_tile.sv
sim/tb_clock.sv
sim/pe_tile_properties.sv
sim/pe_tile_tb.sv

// ==== sim/pe_tile_tb.sv ====
`default_nettype none

`include "cgra_defines.svh"

module pe_tile_tb;

	import cgra_pkg::*;

	localparam logic [15:0] tile_id_c = 16'h0a5c;
	// Well above the roughly 270 cycles the tests take
	localparam int timeout_cycles = 2000;

	logic        clk;
	logic        arst_n;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	logic [15:0] in_wire;
	logic [15:0] out_wire;

	// Expected configuration state
	logic [31:0] sb_word;
	cb_sel_t     cb0_sel;
	cb_sel_t     cb1_sel;
	clb_op_t     op;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	tb_clock clock_gen (.clk(clk));

	pe_tile pe_tile_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.in_wire     (in_wire),
		.out_wire    (out_wire)
	);

	bind pe_tile pe_tile_properties props_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_addr (config_addr),
		.tile_id     (tile_id),
		.en_sb       (cfg_bus.en_sb),
		.en_cb0      (cfg_bus.en_cb0),
		.en_cb1      (cfg_bus.en_cb1),
		.en_clb      (cfg_bus.en_clb)
	);

	// Routing model, assumes no connect box taps a logic-fed output
	function automatic logic [15:0] expected_out(input logic [15:0] in_v);
		logic [15:0] out_v;
		logic [7:0]  taps_0;
		logic [7:0]  taps_1;
		logic        a;
		logic        b;
		logic        r;
		int          s;
		int          t;
		for (int k = 0; k < 16; k++) begin
			s = k / 4;
			t = k % 4;
			case (sb_word[2*k +: 2])
				2'd0: out_v[k] = in_v[((s + 1) % 4) * 4 + t];
				2'd1: out_v[k] = in_v[((s + 2) % 4) * 4 + t];
				2'd2: out_v[k] = in_v[((s + 3) % 4) * 4 + t];
				default: out_v[k] = 1'b0;
			endcase
		end
		taps_0 = {out_v[3:0], in_v[3:0]};
		taps_1 = {out_v[7:4], in_v[7:4]};
		a = taps_0[cb0_sel];
		b = taps_1[cb1_sel];
		case (op)
			op_and: r = a & b;
			op_or: r = a | b;
			op_xor: r = a ^ b;
			default: r = ~(a & b);
		endcase
		for (int k = 0; k < 16; k++) begin
			if (sb_word[2*k +: 2] == 2'd3) begin
				out_v[k] = r;
			end
		end
		return out_v;
	endfunction

	// Sixteen switch-box fields, none taking the logic result
	function automatic logic [31:0] random_sb_word();
		logic [31:0] w;
		for (int k = 0; k < 16; k++) begin
			w[2*k +: 2] = 2'($urandom_range(2, 0));
		end
		return w;
	endfunction

	task automatic write_cfg(input logic [15:0] blk, input logic [15:0] id,
		input logic [31:0] data);
		@(posedge clk);
		config_addr <= {blk, id};
		config_data <= data;
		@(posedge clk);
		config_addr <= {`CGRA_IDLE_BLK, tile_id_c};
	endtask

	task automatic check_routing(input int n);
		logic [15:0] exp;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			in_wire <= 16'($urandom);
			@(negedge clk);
			exp = expected_out(in_wire);
			checks++;
			if (out_wire !== exp) begin
				errors++;
				$display("** Error out_wire: in_wire %h, expected %h, got %h",
					in_wire, exp, out_wire);
			end
		end
	endtask

	task automatic test_reset_routing();
		check_routing(20);
	endtask

	task automatic test_sb_sources();
		logic [31:0] w;
		for (int i = 0; i < 3; i++) begin
			w = random_sb_word();
			write_cfg(`CGRA_BLK_SB, tile_id_c, w);
			sb_word = w;
			check_routing(20);
		end
	endtask

	task automatic test_logic_ops();
		// Logic result only on side 2 track 0
		sb_word = 32'h0003_0000;
		cb0_sel = cb_sel_t'($urandom_range(3, 0));
		cb1_sel = cb_sel_t'($urandom_range(3, 0));
		write_cfg(`CGRA_BLK_SB, tile_id_c, sb_word);
		write_cfg(`CGRA_BLK_CB0, tile_id_c, 32'(cb0_sel));
		write_cfg(`CGRA_BLK_CB1, tile_id_c, 32'(cb1_sel));
		for (int o = 0; o < 4; o++) begin
			write_cfg(`CGRA_BLK_CLB, tile_id_c, 32'(o));
			op = clb_op_t'(o);
			check_routing(20);
		end
	endtask

	task automatic test_output_taps();
		sb_word = random_sb_word();
		sb_word[17:16] = 2'd3;
		write_cfg(`CGRA_BLK_SB, tile_id_c, sb_word);
		write_cfg(`CGRA_BLK_CLB, tile_id_c, 32'(op_xor));
		op = op_xor;
		for (int tap = 4; tap < 8; tap++) begin
			write_cfg(`CGRA_BLK_CB0, tile_id_c, 32'(tap));
			cb0_sel = cb_sel_t'(tap);
			check_routing(10);
		end
	endtask

	// cb0 sits on tap 7 here, so the stray write asks for tap 0
	task automatic test_id_filter();
		write_cfg(`CGRA_BLK_SB, tile_id_c ^ 16'h0001, $urandom);
		write_cfg(`CGRA_BLK_CB0, tile_id_c ^ 16'h8000, 32'h0);
		write_cfg(`CGRA_BLK_CLB, ~tile_id_c, 32'h1);
		write_cfg(16'h0003, tile_id_c, $urandom);
		write_cfg(`CGRA_IDLE_BLK, tile_id_c, $urandom);
		check_routing(20);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hcdd8f4b2));
		arst_n = 1'b0;
		config_addr = {`CGRA_IDLE_BLK, tile_id_c};
		config_data = 32'h0;
		tile_id = tile_id_c;
		in_wire = 16'h0;
		sb_word = 32'h0;
		cb0_sel = 3'd0;
		cb1_sel = 3'd0;
		op = op_and;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		test_reset_routing();
		test_sb_sources();
		test_logic_ops();
		test_output_taps();
		test_id_filter();

		errors += pe_tile_i.props_i.assert_fails;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/pe_tile_properties.sv ====
`default_nettype none

`include "cgra_defines.svh"

module pe_tile_properties (
	input logic                    clk,
	input logic                    arst_n,
	input logic [`CGRA_ADDR_W-1:0] config_addr,
	input logic [`CGRA_ID_W-1:0]   tile_id,
	input logic                    en_sb,
	input logic                    en_cb0,
	input logic                    en_cb1,
	input logic                    en_clb
);

	logic [3:0] en_all;

	// Failed assertions so far
	int assert_fails = 0;

	assign en_all = {en_sb, en_cb0, en_cb1, en_clb};

	enables_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(en_all))
		else begin
			$error("more than one block enable high: %b", en_all);
			assert_fails++;
		end

	// Another tile's address must not write here
	id_mismatch_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(config_addr[`CGRA_ID_W-1:0] != tile_id) |-> (en_all == 4'b0))
		else begin
			$error("enable high with tile id mismatch: %b", en_all);
			assert_fails++;
		end

	idle_block_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(config_addr[`CGRA_ADDR_W-1 -: `CGRA_BLK_W] == `CGRA_IDLE_BLK) |-> (en_all == 4'b0))
		else begin
			$error("enable high on idle block address: %b", en_all);
			assert_fails++;
		end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk
);

	// Period of 4
	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== verilog/pe_tile.sv ====
`default_nettype none

`include "cgra_defines.svh"

module pe_tile (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [`CGRA_ADDR_W-1:0]     config_addr,
	input  logic [`CGRA_CFG_W-1:0]      config_data,
	input  logic [`CGRA_ID_W-1:0]       tile_id,
	input  logic [`CGRA_NUM_TRACKS-1:0] in_wire,
	output logic [`CGRA_NUM_TRACKS-1:0] out_wire
);

	// Operands from the connect boxes
	logic op_0;
	logic op_1;

	// Logic result, routed back through the switch box
	// can close a loop if a connect box taps its own fed output
	logic pe_result;

	tile_cfg_if cfg_bus ();

	config_decode decode (
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.cfg         (cfg_bus.source)
	);

	switch_box sb (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg       (cfg_bus.sink),
		.in_wire   (in_wire),
		.pe_result (pe_result),
		.out_wire  (out_wire)
	);

	// Side 0 operand
	connect_box cb0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_en   (cfg_bus.en_cb0),
		.cfg_data (cfg_bus.data[`CGRA_CB_SEL_W-1:0]),
		.side_in  (in_wire[0 * `CGRA_TRACKS +: `CGRA_TRACKS]),
		.side_out (out_wire[0 * `CGRA_TRACKS +: `CGRA_TRACKS]),
		.operand  (op_0)
	);

	// Side 1 operand
	connect_box cb1 (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_en   (cfg_bus.en_cb1),
		.cfg_data (cfg_bus.data[`CGRA_CB_SEL_W-1:0]),
		.side_in  (in_wire[1 * `CGRA_TRACKS +: `CGRA_TRACKS]),
		.side_out (out_wire[1 * `CGRA_TRACKS +: `CGRA_TRACKS]),
		.operand  (op_1)
	);

	logic_block clb (
		.clk    (clk),
		.arst_n (arst_n),
		.cfg    (cfg_bus.sink),
		.op_0   (op_0),
		.op_1   (op_1),
		.result (pe_result)
	);

endmodule

`default_nettype wire

// ==== verilog/logic_block.sv ====
`default_nettype none

`include "cgra_defines.svh"

module logic_block (
	input  logic     clk,
	input  logic     arst_n,
	tile_cfg_if.sink cfg,
	input  logic     op_0,
	input  logic     op_1,
	output logic     result
);

	import cgra_pkg::*;

	clb_op_t op_q;

	// Reset leaves the block doing AND
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= op_and;
		end else if (cfg.en_clb) begin
			op_q <= clb_op_t'(cfg.data[`CGRA_CLB_OP_W-1:0]);
		end
	end

	always_comb begin
		case (op_q)
			op_and: begin
				result = op_0 & op_1;
			end
			op_or: begin
				result = op_0 | op_1;
			end
			op_xor: begin
				result = op_0 ^ op_1;
			end
			op_nand: begin
				result = ~(op_0 & op_1);
			end
			default: begin
				result = op_0 & op_1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/connect_box.sv ====
`default_nettype none

`include "cgra_defines.svh"

module connect_box (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    cfg_en,
	input  cgra_pkg::cb_sel_t       cfg_data,
	input  logic [`CGRA_TRACKS-1:0] side_in,
	input  logic [`CGRA_TRACKS-1:0] side_out,
	output logic                    operand
);

	import cgra_pkg::*;

	cb_sel_t                   sel_q;
	logic [2*`CGRA_TRACKS-1:0] taps;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (cfg_en) begin
			sel_q <= cfg_data;
		end
	end

	// Inputs on the low taps, switch-box outputs on the high taps
	assign taps = {side_out, side_in};

	// Eight-to-one tap mux
	always_comb begin
		case (sel_q)
			3'd0: operand = taps[0];
			3'd1: operand = taps[1];
			3'd2: operand = taps[2];
			3'd3: operand = taps[3];
			3'd4: operand = taps[4];
			3'd5: operand = taps[5];
			3'd6: operand = taps[6];
			3'd7: operand = taps[7];
			default: operand = taps[0];
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/switch_box.sv ====
`default_nettype none

`include "cgra_defines.svh"

module switch_box (
	input  logic                 clk,
	input  logic                 arst_n,
	tile_cfg_if.sink             cfg,
	input  cgra_pkg::track_vec_t in_wire,
	input  logic                 pe_result,
	output cgra_pkg::track_vec_t out_wire
);

	import cgra_pkg::*;

	genvar s;
	genvar t;

	generate
		for (s = 0; s < `CGRA_SIDES; s++) begin : g_side
			for (t = 0; t < `CGRA_TRACKS; t++) begin : g_track
				// Output track index and its select field position
				localparam int k     = s * `CGRA_TRACKS + t;
				localparam int lsb   = k * `CGRA_SB_SEL_W;

				// Same-numbered track on the other three sides
				localparam int src_1 = ((s + 1) % `CGRA_SIDES) * `CGRA_TRACKS + t;
				localparam int src_2 = ((s + 2) % `CGRA_SIDES) * `CGRA_TRACKS + t;
				localparam int src_3 = ((s + 3) % `CGRA_SIDES) * `CGRA_TRACKS + t;

				sb_sel_t sel_q;
				logic    route;

				// Whole 32-bit word reloads all sixteen fields at once
				always_ff @(posedge clk or negedge arst_n) begin
					if (!arst_n) begin
						sel_q <= sb_from_next;
					end else if (cfg.en_sb) begin
						sel_q <= cfg.data[lsb +: `CGRA_SB_SEL_W];
					end
				end

				always_comb begin
					case (sel_q)
						sb_from_next: begin
							route = in_wire[src_1];
						end
						sb_from_opp: begin
							route = in_wire[src_2];
						end
						sb_from_prev: begin
							route = in_wire[src_3];
						end
						sb_from_pe: begin
							route = pe_result;
						end
						default: begin
							route = in_wire[src_1];
						end
					endcase
				end

				assign out_wire[k] = route;
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== verilog/config_decode.sv ====
`default_nettype none

`include "cgra_defines.svh"

module config_decode (
	input  logic [`CGRA_ADDR_W-1:0] config_addr,
	input  logic [`CGRA_CFG_W-1:0]  config_data,
	input  logic [`CGRA_ID_W-1:0]   tile_id,
	tile_cfg_if.source              cfg
);

	logic [`CGRA_BLK_W-1:0] blk;
	logic                   id_match;

	// Upper half picks the block, lower half addresses the tile
	assign blk      = config_addr[`CGRA_ADDR_W-1 -: `CGRA_BLK_W];
	assign id_match = (config_addr[`CGRA_ID_W-1:0] == tile_id);

	always_comb begin
		cfg.en_sb  = 1'b0;
		cfg.en_cb0 = 1'b0;
		cfg.en_cb1 = 1'b0;
		cfg.en_clb = 1'b0;
		if (id_match) begin
			case (blk)
				`CGRA_BLK_SB: begin
					cfg.en_sb = 1'b1;
				end
				`CGRA_BLK_CB0: begin
					cfg.en_cb0 = 1'b1;
				end
				`CGRA_BLK_CB1: begin
					cfg.en_cb1 = 1'b1;
				end
				`CGRA_BLK_CLB: begin
					cfg.en_clb = 1'b1;
				end
				// Idle address between writes
				`CGRA_IDLE_BLK: begin
				end
				default: begin
				end
			endcase
		end
	end

	// Data goes to every block, only the enabled one takes it
	assign cfg.data = config_data;

endmodule

`default_nettype wire

// ==== verilog/tile_cfg_if.sv ====
`default_nettype none

`include "cgra_defines.svh"

interface tile_cfg_if;

	// Per-block write enables, one-hot or all low
	logic en_sb;
	logic en_cb0;
	logic en_cb1;
	logic en_clb;

	// Shared configuration word
	logic [`CGRA_CFG_W-1:0] data;

	modport source (
		output en_sb,
		output en_cb0,
		output en_cb1,
		output en_clb,
		output data
	);

	modport sink (
		input en_sb,
		input en_cb0,
		input en_cb1,
		input en_clb,
		input data
	);

endinterface

`default_nettype wire

// ==== verilog/cgra_pkg.sv ====
`default_nettype none

`include "cgra_defines.svh"

package cgra_pkg;

	// Track t of side s sits at bit s*4+t
	typedef logic [`CGRA_NUM_TRACKS-1:0] track_vec_t;

	// Switch-box source select, one per output track
	typedef logic [`CGRA_SB_SEL_W-1:0] sb_sel_t;

	// Connect-box tap select
	// 0..3 are input tracks, 4..7 are output tracks of the same side
	typedef logic [`CGRA_CB_SEL_W-1:0] cb_sel_t;

	// Logic-block operation
	typedef enum logic [`CGRA_CLB_OP_W-1:0] {
		op_and  = 2'd0,
		op_or   = 2'd1,
		op_xor  = 2'd2,
		op_nand = 2'd3
	} clb_op_t;

	// Switch-box source codes, sides counted from the output's own side
	localparam sb_sel_t sb_from_next  = 2'd0;
	localparam sb_sel_t sb_from_opp   = 2'd1;
	localparam sb_sel_t sb_from_prev  = 2'd2;
	localparam sb_sel_t sb_from_pe    = 2'd3;

endpackage

`default_nettype wire

// ==== include/cgra_defines.svh ====
`ifndef CGRA_DEFINES_SVH
`define CGRA_DEFINES_SVH

// Tile geometry
`define CGRA_SIDES      4
`define CGRA_TRACKS     4
`define CGRA_NUM_TRACKS (`CGRA_SIDES * `CGRA_TRACKS)

// Configuration bus widths
`define CGRA_ADDR_W     32
`define CGRA_CFG_W      32
`define CGRA_ID_W       16
`define CGRA_BLK_W      16

// Block codes in address bits 31:16
`define CGRA_BLK_SB     16'd7
`define CGRA_BLK_CB0    16'd6
`define CGRA_BLK_CB1    16'd5
`define CGRA_BLK_CLB    16'd4

// Matches no block
`define CGRA_IDLE_BLK   16'd0

// Configuration field widths
`define CGRA_SB_SEL_W   2
`define CGRA_CB_SEL_W   3
`define CGRA_CLB_OP_W   2

`endif
